// ==== flist.f ====
+incdir+verilog
+incdir+verification
verilog/cps_video_pkg.sv
verilog/video_timing.sv
verilog/layer_mmr.sv
verilog/layer_mixer.sv
verilog/palette_ram.sv
verilog/rgb_out.sv
verilog/cps_video_top.sv
verification/tb_cps_video.sv

// ==== verification/tb_cps_video_model.svh ====
// ==================================================
// Reference rules for the video back end testbench
// Priority, colour scaling, raster windows, table
// ==================================================
`ifndef TB_CPS_VIDEO_MODEL_SVH
`define TB_CPS_VIDEO_MODEL_SVH

// Back to front walk, the last opaque enabled slot wins
function automatic logic [10:0] expected_winner(input logic [11:0] cfg,
                                                input logic [10:0] back,
                                                input logic [35:0] pix);
    logic [10:0] addr;
    logic [1:0]  id;
    logic [8:0]  p;
    addr = back;
    for (int s = 0; s < 4; s++) begin
        id = cfg[2*s +: 2];
        // obj sits in the top nine bits, scr3 in the bottom nine
        p  = pix[35 - 9 * id -: 9];
        if (cfg[8 + id] && p[3:0] != `TRANSPARENT_COLOUR) begin
            addr = {id, p};
        end
    end
    return addr;
endfunction

// Nibble times (brightness + 16), halved
function automatic logic [23:0] expected_rgb(input logic [15:0] word);
    int gain;
    gain = word[15:12] + 16;
    return {8'((word[11:8] * gain) / 2), 8'((word[7:4] * gain) / 2),
            8'((word[3:0] * gain) / 2)};
endfunction

// Returned as hb, vb, hs, vs
function automatic logic [3:0] expected_sync(input int h, input int v);
    return {h >= `H_VISIBLE, (v < `V_BLANK_END) || (v >= `V_BLANK_START),
            (h >= `H_SYNC_START) && (h < `H_SYNC_END),
            (v >= `V_SYNC_START) && (v < `V_SYNC_END)};
endfunction

// Byte selects are active low
function automatic logic [15:0] merge_lanes(input logic [15:0] old, input logic [15:0] data,
                                            input logic [1:0] lanes);
    return {lanes[1] ? old[15:8] : data[15:8], lanes[0] ? old[7:0] : data[7:0]};
endfunction

// Random rows, row 0 all transparent and row 1 with every layer off
task automatic build_table();
    for (int i = 0; i < ROWS; i++) begin
        row_cfg[i]  = 12'($random(seed));
        row_back[i] = 11'($random(seed));
        row_pix[i]  = {4'($random(seed)), 32'($random(seed))};
        if (i == 0) begin
            row_cfg[i][11:8] = 4'hf;
            row_pix[i]       = row_pix[i] | {4{9'h00f}};
        end
        if (i == 1) begin
            row_cfg[i][11:8] = 4'h0;
        end
        row_addr[i] = expected_winner(row_cfg[i], row_back[i], row_pix[i]);
    end
endtask

`endif

// ==== verification/tb_cps_video.sv ====
// ==================================================
// Video back end testbench
// Registers, raster timing, layer priority and RGB
// ==================================================
`timescale 1ns/1ps
`include "cps_video_consts.svh"

module tb_cps_video;

    localparam int          ROWS       = 64;
    localparam logic [11:0] CTRL_RESET = {4'hf, 2'd3, 2'd2, 2'd1, 2'd0};

    // One pixel in flight, as the outputs should show it
    typedef struct packed {
        logic        chk;
        logic        hb;
        logic        vb;
        logic [23:0] rgb;
    } expect_t;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         pxl_cen;
    logic                         mmr_cs;
    cps_video_pkg::mmr_reg_e      mmr_addr;
    logic [1:0]                   dsn;
    logic [15:0]                  cpu_dout;
    cps_video_pkg::pal_wr_t       pal_wr;
    cps_video_pkg::layer_pixels_t layers;
    logic [15:0]                  mmr_dout;
    logic [8:0]                   hdump, vdump;
    logic                         hs, vs, hb, vb, line_start, frame_start;
    logic [7:0]                   red, green, blue;
    logic                         lhbl_dly, lvbl_dly;

    // Stimulus table, expected palette address per row
    logic [11:0] row_cfg  [ROWS];
    logic [10:0] row_back [ROWS];
    logic [35:0] row_pix  [ROWS];
    logic [10:0] row_addr [ROWS];
    logic [15:0] pal_sh   [2048];
    logic [11:0] ctrl_sh;
    logic [10:0] back_sh;
    integer      seed   = 32'hc0ce177b;
    int          errors = 0;
    int          checks = 0;
    int          cur_row, h_exp, v_exp;
    logic        check_en;
    expect_t     pipe [$];

    `include "tb_cps_video_model.svh"

    cps_video_top i_dut (
        .HS       ( hs       ),
        .VS       ( vs       ),
        .HB       ( hb       ),
        .VB       ( vb       ),
        .LHBL_dly ( lhbl_dly ),
        .LVBL_dly ( lvbl_dly ),
        .*
    );

    always #20 clk = ~clk;

    // Pixel enable on every second clk
    always @(posedge clk) begin
        pxl_cen <= rst ? 1'b0 : ~pxl_cen;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    // Raster and pipeline checks, sampled on the falling edge
    always @(negedge clk) begin
        expect_t    e;
        logic [3:0] s;
        if (!rst && pxl_cen) begin
            s = expected_sync(h_exp, v_exp);
            check_value("hdump", hdump, h_exp);
            check_value("vdump", vdump, v_exp);
            check_value("HB/VB/HS/VS", {hb, vb, hs, vs}, s);
            e.chk = check_en;
            e.hb  = s[3];
            e.vb  = s[2];
            e.rgb = (s[3] || s[2]) ? 24'd0 : expected_rgb(pal_sh[row_addr[cur_row]]);
            pipe.push_back(e);
            // Position after the coming pxl_cen edge
            if (h_exp == `H_TOTAL - 1) begin
                h_exp = 0;
                v_exp = (v_exp == `V_TOTAL - 1) ? 0 : v_exp + 1;
            end else begin
                h_exp++;
            end
        end else if (!rst && pipe.size() == `PIXEL_LATENCY) begin
            e = pipe.pop_front();
            check_value("LHBL_dly", lhbl_dly, !e.hb);
            check_value("LVBL_dly", lvbl_dly, !e.vb);
            if (e.chk || e.hb || e.vb) begin
                check_value("red/green/blue", {red, green, blue}, e.rgb);
            end
        end
    end

    task automatic write_reg(input cps_video_pkg::mmr_reg_e sel, input logic [1:0] lanes,
                             input logic [15:0] data);
        @(posedge clk);
        mmr_cs   <= 1'b1;
        mmr_addr <= sel;
        dsn      <= lanes;
        cpu_dout <= data;
        @(posedge clk);
        mmr_cs <= 1'b0;
        if (sel == cps_video_pkg::REG_LAYER_CTRL) begin
            ctrl_sh = 12'(merge_lanes({4'd0, ctrl_sh}, data, lanes));
        end else begin
            back_sh = 11'(merge_lanes({5'd0, back_sh}, data, lanes));
        end
        @(negedge clk);
        check_value("mmr_dout", mmr_dout, (sel == cps_video_pkg::REG_LAYER_CTRL) ?
                    {4'd0, ctrl_sh} : {5'd0, back_sh});
    endtask

    // Registers first, pixels once both have settled
    task automatic apply_row(input int i);
        @(posedge clk);
        cur_row = i;
        check_en <= 1'b0;
        mmr_cs   <= 1'b1;
        mmr_addr <= cps_video_pkg::REG_LAYER_CTRL;
        dsn      <= 2'b00;
        cpu_dout <= {4'd0, row_cfg[i]};
        @(posedge clk);
        mmr_addr <= cps_video_pkg::REG_BACKDROP;
        cpu_dout <= {5'd0, row_back[i]};
        @(posedge clk);
        mmr_cs   <= 1'b0;
        layers   <= row_pix[i];
        check_en <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    initial begin
        int          lines;
        int          frames;
        logic [15:0] word;
        rst      = 1'b1;
        pxl_cen  = 1'b0;
        mmr_cs   = 1'b0;
        mmr_addr = cps_video_pkg::REG_LAYER_CTRL;
        dsn      = 2'b11;
        cpu_dout = '0;
        pal_wr   = '0;
        layers   = '0;
        check_en = 1'b0;
        cur_row  = 0;
        h_exp    = 0;
        v_exp    = 0;
        ctrl_sh  = CTRL_RESET;
        back_sh  = '1;
        build_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Reset state, before the first pixel enable
        @(negedge clk);
        check_value("mmr_dout", mmr_dout, {4'd0, CTRL_RESET});
        check_value("red/green/blue", {red, green, blue}, 0);
        check_value("LHBL_dly/LVBL_dly", {lhbl_dly, lvbl_dly}, 0);
        @(posedge clk);
        mmr_addr <= cps_video_pkg::REG_BACKDROP;
        @(negedge clk);
        check_value("mmr_dout", mmr_dout, 16'h07ff);

        // Lane patterns 10, 01 and 00 on both registers
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < 3; k++) begin
                write_reg(cps_video_pkg::mmr_reg_e'(r), 2'(2 - k), 16'($random(seed)));
            end
        end

        // Palette entries that the table reads
        for (int i = 0; i < ROWS; i++) begin
            @(posedge clk);
            word = 16'($random(seed));
            pal_wr <= {1'b1, row_addr[i], word, 2'b00};
            pal_sh[row_addr[i]] = word;
        end
        @(posedge clk);
        pal_wr <= '0;

        // Whole table inside one visible line
        do begin
            @(negedge clk);
        end while (!(line_start && vdump == 9'd20));
        for (int i = 0; i < ROWS; i++) begin
            apply_row(i);
        end
        @(posedge clk);
        check_en <= 1'b0;

        lines  = 0;
        frames = 0;
        repeat (2 * `H_TOTAL * `V_TOTAL) begin
            @(negedge clk);
            lines  += line_start;
            frames += frame_start;
        end
        check_value("line_start count", lines, `V_TOTAL);
        check_value("frame_start count", frames, 1);

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Two frames plus four pixel periods per row, 80 ns each
    initial begin
        #((2 * `H_TOTAL * `V_TOTAL + 4 * ROWS) * 80);
        $display("Timeout, the tests did not finish in time");
        $display("%0d errors in %0d checks", errors, checks);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== verilog/cps_video_top.sv ====
// ================================================
// Video back end top level
// Timing, layer registers and the pixel chain
// ================================================
`timescale 1ns/1ps

module cps_video_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    input  logic                         mmr_cs,
    input  cps_video_pkg::mmr_reg_e      mmr_addr,
    input  logic [1:0]                   dsn,
    input  logic [15:0]                  cpu_dout,
    input  cps_video_pkg::pal_wr_t       pal_wr,
    input  cps_video_pkg::layer_pixels_t layers,
    output logic [15:0]                  mmr_dout,
    output logic [8:0]                   hdump,
    output logic [8:0]                   vdump,
    output logic                         HS,
    output logic                         VS,
    output logic                         HB,
    output logic                         VB,
    output logic                         line_start,
    output logic                         frame_start,
    output logic [7:0]                   red,
    output logic [7:0]                   green,
    output logic [7:0]                   blue,
    output logic                         LHBL_dly,
    output logic                         LVBL_dly
);

    cps_video_pkg::video_sync_t sync;
    cps_video_pkg::video_sync_t mix_sync;
    cps_video_pkg::video_sync_t pal_sync;
    cps_video_pkg::layer_cfg_t  layer_cfg;
    cps_video_pkg::pal_addr_t   backdrop;
    cps_video_pkg::pal_addr_t   mix_addr;
    logic [15:0]                pal_word;

    assign HB = sync.hb;
    assign VB = sync.vb;
    assign HS = sync.hs;
    assign VS = sync.vs;

    video_timing u_timing (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .pxl_cen     ( pxl_cen     ),
        .hdump       ( hdump       ),
        .vdump       ( vdump       ),
        .sync        ( sync        ),
        .line_start  ( line_start  ),
        .frame_start ( frame_start )
    );

    layer_mmr u_mmr (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .mmr_cs      ( mmr_cs      ),
        .mmr_addr    ( mmr_addr    ),
        .dsn         ( dsn         ),
        .cpu_dout    ( cpu_dout    ),
        .mmr_dout    ( mmr_dout    ),
        .layer_cfg   ( layer_cfg   ),
        .backdrop    ( backdrop    )
    );

    // Pixel chain, one stage per pxl_cen
    layer_mixer u_mixer (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .pxl_cen     ( pxl_cen     ),
        .layers      ( layers      ),
        .sync        ( sync        ),
        .layer_cfg   ( layer_cfg   ),
        .backdrop    ( backdrop    ),
        .mix_addr    ( mix_addr    ),
        .mix_sync    ( mix_sync    )
    );

    palette_ram u_pal (
        .clk         ( clk         ),
        .pxl_cen     ( pxl_cen     ),
        .pal_wr      ( pal_wr      ),
        .mix_addr    ( mix_addr    ),
        .mix_sync    ( mix_sync    ),
        .pal_word    ( pal_word    ),
        .pal_sync    ( pal_sync    )
    );

    rgb_out u_rgb (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .pxl_cen     ( pxl_cen     ),
        .pal_word    ( pal_word    ),
        .pal_sync    ( pal_sync    ),
        .red         ( red         ),
        .green       ( green       ),
        .blue        ( blue        ),
        .LHBL_dly    ( LHBL_dly    ),
        .LVBL_dly    ( LVBL_dly    )
    );

endmodule

// ==== verilog/rgb_out.sv ====
// ================================================
// RGB output stage
// Brightness scaling and blanked colour output
// ================================================
`timescale 1ns/1ps

module rgb_out (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    input  logic [15:0]                pal_word,
    input  cps_video_pkg::video_sync_t pal_sync,
    output logic [7:0]                 red,
    output logic [7:0]                 green,
    output logic [7:0]                 blue,
    output logic                       LHBL_dly,
    output logic                       LVBL_dly
);

    logic [4:0] gain;
    logic       blank;

    // Brightness nibble plus 16 gives a gain of 16 to 31
    assign gain  = {1'b1, pal_word[15:12]};
    assign blank = pal_sync.hb || pal_sync.vb;

    // Nibble times gain, halved, peaks at 232
    function automatic logic [7:0] scale(input logic [3:0] nib, input logic [4:0] g);
        logic [8:0] prod;
        prod = nib * g;
        return prod[8:1];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            red      <= '0;
            green    <= '0;
            blue     <= '0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
        end else if (pxl_cen) begin
            LHBL_dly <= ~pal_sync.hb;
            LVBL_dly <= ~pal_sync.vb;
            if (blank) begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end else begin
                red   <= scale(pal_word[11:8], gain);
                green <= scale(pal_word[7:4], gain);
                blue  <= scale(pal_word[3:0], gain);
            end
        end
    end

endmodule

// ==== verilog/palette_ram.sv ====
// ================================================
// Palette RAM
// CPU byte-lane writes, registered pixel read
// ================================================
`timescale 1ns/1ps

module palette_ram (
    input  logic                       clk,
    input  logic                       pxl_cen,
    input  cps_video_pkg::pal_wr_t     pal_wr,
    input  cps_video_pkg::pal_addr_t   mix_addr,
    input  cps_video_pkg::video_sync_t mix_sync,
    output logic [15:0]                pal_word,
    output cps_video_pkg::video_sync_t pal_sync
);

    localparam int DEPTH = 2 ** $bits(cps_video_pkg::pal_addr_t);

    logic [15:0] mem [0:DEPTH-1];

    // CPU side
    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            if (!pal_wr.dsn[0]) begin
                mem[pal_wr.addr][7:0] <= pal_wr.data[7:0];
            end
            if (!pal_wr.dsn[1]) begin
                mem[pal_wr.addr][15:8] <= pal_wr.data[15:8];
            end
        end
    end

    // Pixel side, sync travels with the colour word
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_word <= mem[mix_addr];
            pal_sync <= mix_sync;
        end
    end

endmodule

// ==== verilog/layer_mixer.sv ====
// ================================================
// Layer priority mixer
// Picks the front-most opaque layer per pixel
// ================================================
`timescale 1ns/1ps
`include "cps_video_consts.svh"

module layer_mixer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pxl_cen,
    input  cps_video_pkg::layer_pixels_t layers,
    input  cps_video_pkg::video_sync_t  sync,
    input  cps_video_pkg::layer_cfg_t   layer_cfg,
    input  cps_video_pkg::pal_addr_t    backdrop,
    output cps_video_pkg::pal_addr_t    mix_addr,
    output cps_video_pkg::video_sync_t  mix_sync
);

    cps_video_pkg::pal_addr_t win;

    function automatic cps_video_pkg::layer_pixel_t pick_pixel(
        input cps_video_pkg::layer_pixels_t px,
        input cps_video_pkg::layer_id_e     id
    );
        case (id)
            cps_video_pkg::LAYER_OBJ:  return px.obj;
            cps_video_pkg::LAYER_SCR1: return px.scr1;
            cps_video_pkg::LAYER_SCR2: return px.scr2;
            default:                   return px.scr3;
        endcase
    endfunction

    // Back to front, each opaque enabled layer covers what lies behind
    always_comb begin
        cps_video_pkg::layer_id_e    id;
        cps_video_pkg::layer_pixel_t pix;
        win = backdrop;
        for (int slot = 0; slot < 4; slot++) begin
            id  = layer_cfg.order[slot];
            pix = pick_pixel(layers, id);
            if (layer_cfg.enable[id] && pix.colour != `TRANSPARENT_COLOUR) begin
                win.layer  = id;
                win.pal    = pix.pal;
                win.colour = pix.colour;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            mix_addr <= win;
        end
    end

    // Sync comes out blanked until the pipeline fills
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mix_sync <= 4'b1100;
        end else if (pxl_cen) begin
            mix_sync <= sync;
        end
    end

    // A disabled layer never reaches the palette
    enabled_winner: assert property (
        @(posedge clk) disable iff (rst)
        pxl_cen |=> (mix_addr == $past(backdrop))
                    || $past(layer_cfg.enable[win.layer])
    );

endmodule

// ==== verilog/layer_mmr.sv ====
// ================================================
// Layer control registers
// CPU-written draw order, enables and backdrop
// ================================================
`timescale 1ns/1ps
`include "cps_video_consts.svh"

module layer_mmr (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mmr_cs,
    input  cps_video_pkg::mmr_reg_e   mmr_addr,
    input  logic [1:0]                dsn,
    input  logic [15:0]               cpu_dout,
    output logic [15:0]               mmr_dout,
    output cps_video_pkg::layer_cfg_t layer_cfg,
    output cps_video_pkg::pal_addr_t  backdrop
);

    logic [11:0] ctrl_q;
    logic [10:0] back_q;

    // Byte lanes, dsn[0] low for the low byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_q <= `LAYER_CFG_RESET;
            back_q <= '1;
        end else if (mmr_cs) begin
            case (mmr_addr)
                cps_video_pkg::REG_LAYER_CTRL: begin
                    if (!dsn[0]) begin
                        ctrl_q[7:0] <= cpu_dout[7:0];
                    end
                    if (!dsn[1]) begin
                        ctrl_q[11:8] <= cpu_dout[11:8];
                    end
                end
                default: begin
                    if (!dsn[0]) begin
                        back_q[7:0] <= cpu_dout[7:0];
                    end
                    if (!dsn[1]) begin
                        back_q[10:8] <= cpu_dout[10:8];
                    end
                end
            endcase
        end
    end

    assign layer_cfg = cps_video_pkg::layer_cfg_t'(ctrl_q);
    assign backdrop  = cps_video_pkg::pal_addr_t'(back_q);

    // Unused upper bits read as zero
    always_comb begin
        case (mmr_addr)
            cps_video_pkg::REG_LAYER_CTRL: mmr_dout = {4'd0, ctrl_q};
            default:                       mmr_dout = {5'd0, back_q};
        endcase
    end

    // CPU must select at least one byte on every access
    cs_has_lane: assert property (
        @(posedge clk) disable iff (rst)
        mmr_cs |-> dsn != 2'b11
    );

endmodule

// ==== verilog/video_timing.sv ====
// ================================================
// Raster timing generator
// Pixel and line counters with blanking and sync
// ================================================
`timescale 1ns/1ps
`include "cps_video_consts.svh"

module video_timing (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    output logic [8:0]                 hdump,
    output logic [8:0]                 vdump,
    output cps_video_pkg::video_sync_t sync,
    output logic                       line_start,
    output logic                       frame_start
);

    logic h_wrap;
    logic v_wrap;

    // Last pixel of a line and last line of a frame
    assign h_wrap = hdump == 9'(`H_TOTAL - 1);
    assign v_wrap = vdump == 9'(`V_TOTAL - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump       <= '0;
            vdump       <= '0;
            line_start  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            // Strobes line up with the counters reaching zero
            line_start  <= pxl_cen && h_wrap;
            frame_start <= pxl_cen && h_wrap && v_wrap;
            if (pxl_cen) begin
                if (h_wrap) begin
                    hdump <= '0;
                    if (v_wrap) begin
                        vdump <= '0;
                    end else begin
                        vdump <= vdump + 9'd1;
                    end
                end else begin
                    hdump <= hdump + 9'd1;
                end
            end
        end
    end

    // Decoded straight from the counters, no extra delay
    assign sync.hb = hdump >= `H_VISIBLE;
    assign sync.vb = (vdump < `V_BLANK_END) || (vdump >= `V_BLANK_START);
    assign sync.hs = (hdump >= `H_SYNC_START) && (hdump < `H_SYNC_END);
    assign sync.vs = (vdump >= `V_SYNC_START) && (vdump < `V_SYNC_END);

    // Counters never leave the raster
    hdump_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (hdump < `H_TOTAL) && (vdump < `V_TOTAL)
    );

endmodule

// ==== verilog/cps_video_pkg.sv ====
// ================================================
// Video back end types
// Pixel, layer, sync, palette and register types
// ================================================
`include "cps_video_consts.svh"

package cps_video_pkg;

    // One rendered pixel of a layer
    typedef struct packed {
        logic [4:0] pal;
        logic [3:0] colour;
    } layer_pixel_t;

    // All four layers for the same screen position
    typedef struct packed {
        layer_pixel_t obj;
        layer_pixel_t scr1;
        layer_pixel_t scr2;
        layer_pixel_t scr3;
    } layer_pixels_t;

    typedef enum logic [1:0] {
        LAYER_OBJ  = 2'd0,
        LAYER_SCR1 = 2'd1,
        LAYER_SCR2 = 2'd2,
        LAYER_SCR3 = 2'd3
    } layer_id_e;

    // Slot 0 is drawn first, slot 3 ends up in front
    typedef struct packed {
        logic [3:0]          enable;
        layer_id_e [3:0]     order;
    } layer_cfg_t;

    typedef struct packed {
        layer_id_e  layer;
        logic [4:0] pal;
        logic [3:0] colour;
    } pal_addr_t;

    // CPU palette write, byte selects active low
    typedef struct packed {
        logic        we;
        pal_addr_t   addr;
        logic [15:0] data;
        logic [1:0]  dsn;
    } pal_wr_t;

    typedef struct packed {
        logic hb;
        logic vb;
        logic hs;
        logic vs;
    } video_sync_t;

    typedef enum logic {
        REG_LAYER_CTRL = `MMR_LAYER_CTRL_ADDR,
        REG_BACKDROP   = `MMR_BACKDROP_ADDR
    } mmr_reg_e;

endpackage

// ==== verilog/cps_video_consts.svh ====
// ================================================
// Video back end constants
// Raster geometry, register map and pipeline depth
// ================================================
`ifndef CPS_VIDEO_CONSTS_SVH
`define CPS_VIDEO_CONSTS_SVH

// Frame geometry in pixels and lines
`define H_TOTAL             512
`define V_TOTAL             262

// Visible area
`define H_VISIBLE           384
`define V_BLANK_END         16
`define V_BLANK_START       240

// Sync pulses, lower bound inside, upper bound outside
`define H_SYNC_START        448
`define H_SYNC_END          480
`define V_SYNC_START        244
`define V_SYNC_END          248

// CPU register map
`define MMR_LAYER_CTRL_ADDR 1'b0
`define MMR_BACKDROP_ADDR   1'b1

// Default draw order obj, scr1, scr2, scr3 with all layers on
`define LAYER_CFG_RESET     12'hfe4

`define PIXEL_LATENCY       3
`define TRANSPARENT_COLOUR  4'hf

`endif
